/* hdl/serdes_pkg.sv */
package serdes_pkg;

    localparam int LEVEL_W = 8;                      // line voltage width
    localparam int COUNT_W = 16;                     // bit / error counter width
    localparam int PRBS_LEN = 7;                     // prbs7 register length

    typedef logic signed [LEVEL_W-1:0] level_t;      // signed voltage level
    typedef logic [1:0] symbol_t;                    // pam4 index, rising level order
    typedef logic [COUNT_W-1:0] count_t;             // saturating counter value

    // checker FSM states
    typedef enum logic [1:0] {
        CHK_IDLE,                                    // nothing received yet
        CHK_SEED,                                    // filling checker register
        CHK_CHECK                                    // comparing against prediction
    } chk_state_t;

    // pam4 levels, equally spaced by 64
    localparam level_t LEVEL_0 = -8'sd96;
    localparam level_t LEVEL_1 = -8'sd32;
    localparam level_t LEVEL_2 = 8'sd32;
    localparam level_t LEVEL_3 = 8'sd96;

    // slicer thresholds, midway between levels
    localparam level_t SLICE_LO = -8'sd64;
    localparam level_t SLICE_MID = 8'sd0;
    localparam level_t SLICE_HI = 8'sd64;

    localparam int ISI_SHIFT = 2;                    // isi = previous level / 4

    localparam logic [PRBS_LEN-1:0] PRBS_SEED = 7'h7F;   // generator reset value
    localparam logic [7:0] NOISE_SEED = 8'hA5;            // noise lfsr reset value

endpackage

/* hdl/prbs_gen.sv */
`timescale 1ns/100ps

module prbs_gen (
    input  logic clk,
    input  logic rst,
    input  logic link_en,         // advance one bit per enabled cycle
    input  logic inject_err,      // flip the outgoing bit
    output logic prbs_bit,
    output logic prbs_valid
);

    logic [serdes_pkg::PRBS_LEN-1:0] prbs_q;   // x^7 + x^6 + 1 state
    logic                            fb;       // next sequence bit

    // taps at bits 6 and 5
    assign fb = prbs_q[serdes_pkg::PRBS_LEN-1] ^ prbs_q[serdes_pkg::PRBS_LEN-2];

    always_ff @(posedge clk) begin
        if (rst) begin
            prbs_q <= serdes_pkg::PRBS_SEED;
        end else if (link_en) begin
            prbs_q <= {prbs_q[serdes_pkg::PRBS_LEN-2:0], fb};   // shift in at bit 0
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prbs_valid <= 1'b0;
        end else begin
            prbs_valid <= link_en;                // one bit per enabled cycle
        end
    end

    // error only touches the output, state keeps the clean sequence
    always_ff @(posedge clk) begin
        if (link_en) begin
            prbs_bit <= fb ^ inject_err;
        end
    end

    // all-zero state would lock the generator up
    a_prbs_nonzero: assert property (
        @(posedge clk) disable iff (rst) prbs_q != '0
    );

endmodule

/* hdl/pam4_tx.sv */
`timescale 1ns/100ps

module pam4_tx (
    input  logic               clk,
    input  logic               rst,
    input  logic               prbs_bit,
    input  logic               prbs_valid,
    output serdes_pkg::level_t tx_level,
    output logic               tx_valid
);

    logic                first_bit;   // high bit of the pair
    logic                half;        // first bit captured, waiting for second
    serdes_pkg::symbol_t sym;         // gray coded pair
    serdes_pkg::level_t  level;       // mapped voltage

    always_comb begin
        sym = {first_bit, first_bit ^ prbs_bit};   // 00,01,11,10 -> 0,1,2,3
        case (sym)
            2'd0:    level = serdes_pkg::LEVEL_0;
            2'd1:    level = serdes_pkg::LEVEL_1;
            2'd2:    level = serdes_pkg::LEVEL_2;
            default: level = serdes_pkg::LEVEL_3;
        endcase
    end

    // pair assembly, a half pair simply waits through idle time
    always_ff @(posedge clk) begin
        if (rst) begin
            half     <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= prbs_valid & half;        // second bit completes a symbol
            if (prbs_valid) begin
                half <= ~half;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prbs_valid && !half) begin
            first_bit <= prbs_bit;                // hold msb
        end
        if (prbs_valid && half) begin
            tx_level <= level;                    // register the level
        end
    end

endmodule

/* hdl/channel_isi.sv */
`timescale 1ns/100ps

module channel_isi (
    input  logic               clk,
    input  logic               rst,
    input  serdes_pkg::level_t tx_level,
    input  logic               tx_valid,
    output serdes_pkg::level_t line_level,
    output logic               line_valid
);

    serdes_pkg::level_t prev_level;   // last transmitted level, isi source
    serdes_pkg::level_t isi;          // quarter of prev level
    serdes_pkg::level_t noise;        // -4 .. +3
    logic [7:0]         noise_lfsr;   // x^8+x^6+x^5+x^4+1
    logic               noise_fb;

    assign isi = prev_level >>> serdes_pkg::ISI_SHIFT;                // arithmetic shift keeps sign
    assign noise = {{5{noise_lfsr[2]}}, noise_lfsr[2:0]};               // low 3 bits as signed
    assign noise_fb = noise_lfsr[7] ^ noise_lfsr[5] ^ noise_lfsr[4] ^ noise_lfsr[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_level <= '0;                         // quiet line before first symbol
            noise_lfsr <= serdes_pkg::NOISE_SEED;
            line_valid <= 1'b0;
        end else begin
            line_valid <= tx_valid;                   // one cycle through the channel
            if (tx_valid) begin
                prev_level <= tx_level;
                noise_lfsr <= {noise_lfsr[6:0], noise_fb};   // step after each symbol
            end
        end
    end

    // worst case 96 + 24 + 3 = 123 fits in 8 bits signed
    always_ff @(posedge clk) begin
        if (tx_valid) begin
            line_level <= tx_level + isi + noise;
        end
    end

endmodule

/* hdl/dfe_slicer.sv */
`timescale 1ns/100ps

module dfe_slicer (
    input  logic               clk,
    input  logic               rst,
    input  serdes_pkg::level_t line_level,
    input  logic               line_valid,
    output logic               rx_bit,
    output logic               rx_valid
);

    serdes_pkg::level_t  dec_prev;   // last decided level, feedback tap
    logic signed [8:0]   eq_level;   // equalized sample, spare headroom bit
    serdes_pkg::symbol_t sym;        // slicer decision
    serdes_pkg::level_t  dec_level;  // ideal level of the decision
    logic                low_bit;    // second bit waiting to go out
    logic                pend;       // low_bit still owed

    // cancel the one-tap postcursor
    assign eq_level = line_level - (dec_prev >>> serdes_pkg::ISI_SHIFT);

    always_comb begin
        if (eq_level < serdes_pkg::SLICE_LO) begin
            sym = 2'd0;
        end else if (eq_level < serdes_pkg::SLICE_MID) begin
            sym = 2'd1;
        end else if (eq_level < serdes_pkg::SLICE_HI) begin
            sym = 2'd2;
        end else begin
            sym = 2'd3;
        end
        case (sym)
            2'd0:    dec_level = serdes_pkg::LEVEL_0;
            2'd1:    dec_level = serdes_pkg::LEVEL_1;
            2'd2:    dec_level = serdes_pkg::LEVEL_2;
            default: dec_level = serdes_pkg::LEVEL_3;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_prev <= '0;                       // matches channel's quiet start
            pend     <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= line_valid | pend;        // msb now, lsb next cycle
            pend     <= line_valid;
            if (line_valid) begin
                dec_prev <= dec_level;
            end
        end
    end

    // gray decode: msb is sym[1], lsb is sym[1]^sym[0]
    always_ff @(posedge clk) begin
        if (line_valid) begin
            rx_bit  <= sym[1];
            low_bit <= sym[1] ^ sym[0];
        end else if (pend) begin
            rx_bit  <= low_bit;
        end
    end

    // tx pairs bits, so symbols come at most every other cycle
    a_no_overrun: assert property (
        @(posedge clk) disable iff (rst) line_valid |-> !pend
    );

endmodule

/* hdl/link_ctrl.sv */
`timescale 1ns/100ps

module link_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  logic               rx_bit,
    input  logic               rx_valid,
    output logic               link_en,
    output logic               locked,
    output serdes_pkg::count_t bit_count,
    output serdes_pkg::count_t err_count
);

    localparam int SEED_W = $clog2(serdes_pkg::PRBS_LEN + 1);

    serdes_pkg::chk_state_t          state;
    logic [serdes_pkg::PRBS_LEN-1:0] chk_reg;    // last 7 received bits
    logic [SEED_W-1:0]               seed_cnt;   // bits loaded so far
    logic                            predict;    // expected next bit
    logic                            mismatch;

    assign predict = chk_reg[serdes_pkg::PRBS_LEN-1] ^ chk_reg[serdes_pkg::PRBS_LEN-2];
    assign mismatch = rx_bit ^ predict;
    assign locked = (state == serdes_pkg::CHK_CHECK);

    always_ff @(posedge clk) begin
        if (rst) begin
            link_en <= 1'b0;
        end else begin
            link_en <= enable;                    // one register stage to the generator
        end
    end

    // self-synchronizing checker, received bits always feed the register
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= serdes_pkg::CHK_IDLE;
            chk_reg   <= '0;
            seed_cnt  <= '0;
            bit_count <= '0;
            err_count <= '0;
        end else if (rx_valid) begin
            chk_reg <= {chk_reg[serdes_pkg::PRBS_LEN-2:0], rx_bit};
            case (state)
                serdes_pkg::CHK_IDLE: begin
                    seed_cnt <= SEED_W'(1);               // first bit counts toward seed
                    state    <= serdes_pkg::CHK_SEED;
                end
                serdes_pkg::CHK_SEED: begin
                    seed_cnt <= seed_cnt + 1'b1;
                    if (seed_cnt == SEED_W'(serdes_pkg::PRBS_LEN - 1)) begin
                        state <= serdes_pkg::CHK_CHECK;   // register full
                    end
                end
                serdes_pkg::CHK_CHECK: begin
                    if (bit_count != '1) begin
                        bit_count <= bit_count + 1'b1;   // saturate
                    end
                    if (mismatch && err_count != '1) begin
                        err_count <= err_count + 1'b1;
                    end
                end
                default: begin
                    state <= serdes_pkg::CHK_IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/serdes_top.sv */
`timescale 1ns/100ps

module serdes_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,        // link on/off level
    input  logic               inject_err,    // single-bit flip at the source
    output serdes_pkg::level_t line_level,
    output logic               line_valid,
    output logic               rx_bit,
    output logic               rx_valid,
    output logic               locked,
    output serdes_pkg::count_t bit_count,
    output serdes_pkg::count_t err_count
);

    logic               link_en;      // registered enable
    logic               prbs_bit;
    logic               prbs_valid;
    serdes_pkg::level_t tx_level;
    logic               tx_valid;

    link_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .rx_bit    (rx_bit),
        .rx_valid  (rx_valid),
        .link_en   (link_en),
        .locked    (locked),
        .bit_count (bit_count),
        .err_count (err_count)
    );

    prbs_gen u_prbs (
        .clk        (clk),
        .rst        (rst),
        .link_en    (link_en),
        .inject_err (inject_err),
        .prbs_bit   (prbs_bit),
        .prbs_valid (prbs_valid)
    );

    pam4_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .prbs_bit   (prbs_bit),
        .prbs_valid (prbs_valid),
        .tx_level   (tx_level),
        .tx_valid   (tx_valid)
    );

    channel_isi u_channel (
        .clk        (clk),
        .rst        (rst),
        .tx_level   (tx_level),
        .tx_valid   (tx_valid),
        .line_level (line_level),   // also visible at top
        .line_valid (line_valid)
    );

    dfe_slicer u_rx (
        .clk        (clk),
        .rst        (rst),
        .line_level (line_level),
        .line_valid (line_valid),
        .rx_bit     (rx_bit),
        .rx_valid   (rx_valid)
    );

endmodule

/* verification/serdes_tb.sv */
`timescale 1ns/100ps

module serdes_tb;

    localparam int RUN_BITS = 1600;   // random phase length in generated bits
    localparam int MAX_CYCLES = 6000; // ~2 cycles per bit with pauses plus idle and drain
    localparam int INJ_GAP = 20;      // min bits between injected errors
    localparam int INJ_STOP = 40;     // no injection this close to the end of the run

    logic               clk;
    logic               rst;
    logic               enable;
    logic               inject_err;
    serdes_pkg::level_t line_level;
    logic               line_valid;
    logic               rx_bit;
    logic               rx_valid;
    logic               locked;
    serdes_pkg::count_t bit_count;
    serdes_pkg::count_t err_count;

    logic [6:0] m_prbs;       // model generator register
    logic [7:0] m_noise;      // model noise lfsr
    logic       m_link_en;    // enable as seen by the generator
    logic       m_half;       // first bit of a pair held
    logic       m_first;
    int         m_prev;       // previous transmitted level
    logic [6:0] m_chk;        // checker register, built from expected bits
    int         m_bits;       // predicted bit_count
    int         m_errs;       // predicted err_count
    int         n_rx;         // bits received so far
    int         n_gen;        // bits generated so far
    int         n_inj;        // injections that hit a bit
    int         since_inj;    // bits generated since last injection
    int         next_gap;
    logic       exp_bits[$];  // transmitted bits not yet received
    int         exp_lines[$]; // expected line levels in order
    int         fails[1:6];
    int         cycles;
    int         n_checks;
    int         total;
    int         hold_bits;
    int         hold_errs;
    int         resume_rx;

    serdes_top dut (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .inject_err (inject_err),
        .line_level (line_level),
        .line_valid (line_valid),
        .rx_bit     (rx_bit),
        .rx_valid   (rx_valid),
        .locked     (locked),
        .bit_count  (bit_count),
        .err_count  (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;     // 10 ns period
    end

    // gray pair to level with the first bit as msb
    function automatic int gray_level(logic b1, logic b0);
        case ({b1, b0})
            2'b00:   return -96;
            2'b01:   return -32;
            2'b11:   return 32;
            default: return 96;
        endcase
    endfunction

    // low 3 lfsr bits read as two's complement
    function automatic int noise_value(logic [7:0] lfsr);
        int v;
        v = int'(lfsr[2:0]);
        if (v > 3) begin
            v = v - 8;
        end
        return v;
    endfunction

    task automatic report_mismatch(input int test, input string sig, input int got,
                                   input int exp);
        $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, sig, got, exp);
        fails[test]++;
    endtask

    task automatic report_error(input int test, input string msg);
        $display("ERROR at %0t ns in test %0d: %s", $time, test, msg);
        fails[test]++;
    endtask

    // outputs are stable at the falling edge
    task automatic check_outputs();
        int   exp;
        logic e;
        n_checks++;
        if (line_valid) begin
            if (exp_lines.size() == 0) begin
                report_error(2, "line_valid high while nothing was transmitted");
            end else begin
                exp = exp_lines.pop_front();
                if (int'(line_level) != exp) begin
                    report_mismatch(2, "line_level", int'(line_level), exp);
                end
            end
        end
        if (int'(locked) != int'(n_rx >= 7)) begin
            report_mismatch(4, "locked", int'(locked), int'(n_rx >= 7));
        end
        if (int'(bit_count) != m_bits) begin
            report_mismatch(4, "bit_count", int'(bit_count), m_bits);
        end
        if (int'(err_count) != m_errs) begin
            report_mismatch(5, "err_count", int'(err_count), m_errs);
        end
        if (rx_valid) begin
            if (exp_bits.size() == 0) begin
                report_error(3, "rx_valid high while no bit is outstanding");
            end else begin
                e = exp_bits.pop_front();
                if (rx_bit !== e) begin
                    report_mismatch(3, "rx_bit", int'(rx_bit), int'(e));
                end
                if (n_rx >= 7) begin                  // checker seeded
                    m_bits++;
                    if ((m_chk[6] ^ m_chk[5]) != e) begin
                        m_errs++;
                    end
                end
                m_chk = {m_chk[5:0], e};
                n_rx++;
            end
        end
    endtask

    // one rising edge of the whole chain as seen through the current inputs
    task automatic model_cycle();
        logic fb;
        logic b;
        int   lvl;
        if (m_link_en) begin
            fb = m_prbs[6] ^ m_prbs[5];               // x^7 + x^6 + 1
            b = fb ^ inject_err;                      // flip the output only
            m_prbs = {m_prbs[5:0], fb};
            n_gen++;
            since_inj++;
            if (inject_err) begin
                n_inj++;
                since_inj = 0;
            end
            exp_bits.push_back(b);
            if (m_half) begin
                lvl = gray_level(m_first, b);
                exp_lines.push_back(lvl + m_prev / 4 + noise_value(m_noise));
                m_prev = lvl;
                m_noise = {m_noise[6:0], m_noise[7] ^ m_noise[5] ^ m_noise[4] ^ m_noise[3]};
            end else begin
                m_first = b;
            end
            m_half = ~m_half;
        end
        m_link_en = enable;                           // registered in the control block
    endtask

    task automatic advance_cycle();
        @(negedge clk);
        check_outputs();
        model_cycle();
        inject_err = 1'b0;                            // single-cycle pulse
    endtask

    task automatic run_bursts();
        int len;
        while (n_gen < RUN_BITS) begin
            len = 1 + int'($urandom % 40);
            enable = 1'b1;
            repeat (len) begin
                if (m_link_en && n_rx >= 7 && since_inj >= next_gap
                    && n_gen < RUN_BITS - INJ_STOP) begin
                    inject_err = 1'b1;
                    next_gap = INJ_GAP + int'($urandom % 30);
                end
                advance_cycle();
            end
            len = 1 + int'($urandom % 40);
            enable = 1'b0;
            repeat (len) begin
                advance_cycle();
            end
        end
    endtask

    // a held half pair stays in the queue until the link resumes
    task automatic drain_link();
        enable = 1'b0;
        repeat (2) begin
            advance_cycle();
        end
        while (exp_bits.size() > int'(m_half) || exp_lines.size() != 0) begin
            advance_cycle();
        end
        repeat (2) begin
            advance_cycle();                          // last counter update
        end
    endtask

    task automatic print_result(input int test, input string what);
        if (fails[test] == 0) begin
            $display("test %0d %s: ok", test, what);
        end else begin
            $display("test %0d %s: %0d errors", test, what, fails[test]);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        enable = 1'b0;
        inject_err = 1'b0;
        m_prbs = serdes_pkg::PRBS_SEED;
        m_noise = serdes_pkg::NOISE_SEED;
        m_link_en = 1'b0;
        m_half = 1'b0;
        m_first = 1'b0;
        m_prev = 0;                                   // quiet line before first symbol
        m_chk = '0;
        m_bits = 0;
        m_errs = 0;
        n_rx = 0;
        n_gen = 0;
        n_inj = 0;
        since_inj = 0;
        n_checks = 0;
        foreach (fails[i]) begin
            fails[i] = 0;
        end
        void'($urandom(32'h38cc_1247));
        next_gap = INJ_GAP + int'($urandom % 30);
        repeat (3) @(negedge clk);
        rst = 1'b0;

        repeat (10) begin
            advance_cycle();
            if (rx_valid || line_valid || locked || bit_count != 0 || err_count != 0) begin
                report_error(1, "link active or counters nonzero before enable");
            end
        end
        print_result(1, "reset state");

        run_bursts();
        drain_link();
        if (n_inj == 0) begin
            report_error(5, "no error was injected");
        end
        if (int'(err_count) != 3 * n_inj) begin
            report_mismatch(5, "err_count", int'(err_count), 3 * n_inj);
        end
        print_result(2, "line levels");
        print_result(3, "received bits");
        print_result(4, "lock and bit count");
        print_result(5, "error injection");

        repeat (20) begin
            advance_cycle();                          // link stays off
        end
        hold_bits = int'(bit_count);
        hold_errs = int'(err_count);
        repeat (10) begin
            advance_cycle();
            if (int'(bit_count) != hold_bits) begin
                report_mismatch(6, "bit_count", int'(bit_count), hold_bits);
            end
            if (int'(err_count) != hold_errs) begin
                report_mismatch(6, "err_count", int'(err_count), hold_errs);
            end
        end
        resume_rx = n_rx;
        enable = 1'b1;
        repeat (40) begin
            advance_cycle();
        end
        drain_link();
        if (n_rx <= resume_rx) begin
            report_error(6, "no bits received after the link resumed");
        end
        if (int'(err_count) != hold_errs) begin
            report_mismatch(6, "err_count", int'(err_count), hold_errs);
        end
        if (int'(bit_count) != hold_bits + n_rx - resume_rx) begin
            report_mismatch(6, "bit_count", int'(bit_count), hold_bits + n_rx - resume_rx);
        end
        print_result(6, "pause and resume");

        total = fails[1] + fails[2] + fails[3] + fails[4] + fails[5] + fails[6];
        $display("%0d cycles checked, %0d bits received, %0d errors injected, %0d failures",
                 n_checks, n_rx, n_inj, total);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* build.f */
hdl/serdes_pkg.sv
hdl/prbs_gen.sv
hdl/pam4_tx.sv
hdl/channel_isi.sv
hdl/dfe_slicer.sv
hdl/link_ctrl.sv
hdl/serdes_top.sv
verification/serdes_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the serdes testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module serdes_tb -Mdir obj_dir \
    -f build.f > build.log 2>&1 || { echo "compile failed, see build.log"; exit 1; }
./obj_dir/Vserdes_tb > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
